// ==== common/tx_bridge_params.svh ====
// ====================
// Widths, depths and command-word field positions for the
// Avalon to PCIe transmit bridge. Include wherever a macro is used
// ====================
`ifndef TX_BRIDGE_PARAMS_SVH
`define TX_BRIDGE_PARAMS_SVH

`define AVL_ADDR_W      24   // Avalon byte address
`define DATA_W          32
`define MAX_BURST       4
`define BURST_W         3
`define A2P_ENTRIES     4
`define A2P_PASS_BITS   22   // Low address bits kept as is
`define CFG_ADDR_W      3    // Word 2i low half, 2i+1 high half of entry i
`define CMD_FIFO_DEPTH  8
`define WDAT_FIFO_DEPTH 16
`define CMD_W           72

// Command word layout
`define CMD_WR_BIT      71
`define CMD_LEN_HI      70
`define CMD_LEN_LO      68
`define CMD_FBE_HI      67
`define CMD_FBE_LO      64
`define CMD_ADDR_HI     63
`define CMD_ADDR_LO     0

`endif

// ==== common/avl_bridge_pkg.sv ====
// ====================
// Avalon-side and translation-table types, used by the slave front
// end, the table registers, the translator and the formatter
// ====================
`include "tx_bridge_params.svh"

package avl_bridge_pkg;

  typedef logic [`AVL_ADDR_W-1:0]            avl_addr_t;
  typedef logic [`DATA_W-1:0]                data_word_t;
  typedef logic [`BURST_W-1:0]               burst_t;
  typedef logic [`DATA_W/8-1:0]              byte_en_t;
  typedef logic [$clog2(`A2P_ENTRIES)-1:0]   a2p_idx_t;
  typedef logic [`CFG_ADDR_W-1:0]            cfg_addr_t;

  // One 64-bit PCIe base per entry, entry 0 in the low bits
  typedef logic [`A2P_ENTRIES*64-1:0]        a2p_table_t;

endpackage

// ==== common/pcie_tlp_pkg.sv ====
// ====================
// TLP field types, format codes and the command word that the
// translator hands to the formatter through the command FIFO
// ====================
`include "tx_bridge_params.svh"

package pcie_tlp_pkg;

  typedef logic [63:0]         pcie_addr_t;
  typedef logic [2:0]          tlp_fmt_t;
  typedef logic [9:0]          tlp_len_t;   // In DWs
  typedef logic [7:0]          tlp_tag_t;
  typedef logic [15:0]         req_id_t;    // Bus/device/function
  typedef logic [`CMD_W-1:0]   tx_cmd_t;

  // Fmt field, 3-DW or 4-DW header with or without data
  localparam tlp_fmt_t MRd32 = 3'b000;
  localparam tlp_fmt_t MRd64 = 3'b001;
  localparam tlp_fmt_t MWr32 = 3'b010;
  localparam tlp_fmt_t MWr64 = 3'b011;

endpackage

// ==== common/a2p_req_if.sv ====
// ====================
// Command from the Avalon slave to the address translator.
// valid is a single-cycle pulse, there is no back-pressure
// ====================
interface a2p_req_if;
  import avl_bridge_pkg::*;

  logic      valid;
  logic      write;
  avl_addr_t addr;    // Byte address
  burst_t    len;     // Beats, 1 to 4
  byte_en_t  fbe;     // First beat byte enables

  modport src (
    output valid, write, addr, len, fbe
  );

  modport dst (
    input valid, write, addr, len, fbe
  );

endinterface

// ==== src/sync_fifo.sv ====
// ====================
// Synchronous FIFO with a registered read port. data_o updates the
// cycle after pop_i and then holds. free_o counts empty slots
// ====================
module sync_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 8
) (
  input  logic                       Clk_i,
  input  logic                       Rstn_i,
  input  logic                       push_i,
  input  logic [WIDTH-1:0]           data_i,
  input  logic                       pop_i,
  output logic [WIDTH-1:0]           data_o,
  output logic                       empty_o,
  output logic [$clog2(DEPTH+1)-1:0] free_o
);
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH+1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [CW-1:0]    count;
  logic             do_push;
  logic             do_pop;

  assign do_push = push_i && (count != CW'(DEPTH));  // Overflow dropped
  assign do_pop  = pop_i && (count != '0);
  assign empty_o = (count == '0);
  assign free_o  = CW'(DEPTH) - count;

  always_ff @(posedge Clk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      count <= count + CW'(do_push) - CW'(do_pop);
    end
  end

  always_ff @(posedge Clk_i)
  begin
    if (do_push)
      mem[wr_ptr] <= data_i;
    if (do_pop)
      data_o <= mem[rd_ptr];  // Read register
  end

endmodule

// ==== a2p/a2p_table_regs.sv ====
// ====================
// Translation table registers behind the configuration port.
// Eight 32-bit words, read data returned one cycle after the request
// ====================
`include "tx_bridge_params.svh"

module a2p_table_regs (
  input  logic                       Clk_i,
  input  logic                       Rstn_i,
  input  avl_bridge_pkg::cfg_addr_t  cfg_address_i,
  input  logic                       cfg_write_i,
  input  avl_bridge_pkg::data_word_t cfg_write_data_i,
  input  logic                       cfg_read_i,
  output avl_bridge_pkg::data_word_t cfg_read_data_o,
  output logic                       cfg_read_valid_o,
  output avl_bridge_pkg::a2p_table_t table_o
);
  import avl_bridge_pkg::*;

  data_word_t regs [2*`A2P_ENTRIES];

  always_ff @(posedge Clk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      for (int i = 0; i < 2*`A2P_ENTRIES; i++)
        regs[i] <= '0;
      cfg_read_valid_o <= 1'b0;
    end
    else
    begin
      if (cfg_write_i)
        regs[cfg_address_i] <= cfg_write_data_i;
      cfg_read_valid_o <= cfg_read_i;
    end
  end

  always_ff @(posedge Clk_i)
  begin
    if (cfg_read_i)
      cfg_read_data_o <= regs[cfg_address_i];
  end

  // Word k lands at bits k*32, so entry i is {word 2i+1, word 2i}
  always_comb
  begin
    for (int k = 0; k < 2*`A2P_ENTRIES; k++)
      table_o[k*`DATA_W +: `DATA_W] = regs[k];
  end

endmodule

// ==== a2p/a2p_translate.sv ====
// ====================
// Avalon to PCIe address translation, one register stage.
// Each request pulse becomes a command-word push on the next cycle
// ====================
`include "tx_bridge_params.svh"

module a2p_translate (
  input  logic                       Clk_i,
  input  logic                       Rstn_i,
  a2p_req_if.dst                     req,
  input  avl_bridge_pkg::a2p_table_t table_i,
  output logic                       cmd_push_o,
  output pcie_tlp_pkg::tx_cmd_t      cmd_o
);
  import avl_bridge_pkg::*;
  import pcie_tlp_pkg::*;

  a2p_idx_t   idx;
  pcie_addr_t entry;
  pcie_addr_t pcie_addr;

  // Upper address bits pick the entry
  assign idx   = req.addr[`AVL_ADDR_W-1:`A2P_PASS_BITS];
  assign entry = table_i[idx*64 +: 64];

  // Base from the table, offset straight from Avalon
  assign pcie_addr = {entry[63:`A2P_PASS_BITS], req.addr[`A2P_PASS_BITS-1:0]};

  always_ff @(posedge Clk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      cmd_push_o <= 1'b0;
    else
      cmd_push_o <= req.valid;
  end

  always_ff @(posedge Clk_i)
  begin
    if (req.valid)
    begin
      cmd_o[`CMD_WR_BIT]              <= req.write;
      cmd_o[`CMD_LEN_HI:`CMD_LEN_LO]   <= req.len;
      cmd_o[`CMD_FBE_HI:`CMD_FBE_LO]   <= req.fbe;
      cmd_o[`CMD_ADDR_HI:`CMD_ADDR_LO] <= pcie_addr;
    end
  end

endmodule

// ==== src/avl_tx_slave.sv ====
// ====================
// Avalon-MM slave front end. Accepts a command only when both FIFOs
// have room, then takes the rest of a write burst without waiting
// ====================
`include "tx_bridge_params.svh"

module avl_tx_slave (
  input  logic                                      Clk_i,
  input  logic                                      Rstn_i,
  input  logic                                      avl_read_i,
  input  logic                                      avl_write_i,
  input  avl_bridge_pkg::avl_addr_t                 avl_address_i,
  input  avl_bridge_pkg::burst_t                    avl_burst_count_i,
  input  avl_bridge_pkg::byte_en_t                  avl_byte_enable_i,
  input  avl_bridge_pkg::data_word_t                avl_write_data_i,
  output logic                                      avl_wait_request_o,
  input  logic [$clog2(`CMD_FIFO_DEPTH+1)-1:0]      cmd_free_i,
  input  logic [$clog2(`WDAT_FIFO_DEPTH+1)-1:0]     wdat_free_i,
  output logic                                      wdat_push_o,
  output avl_bridge_pkg::data_word_t                wdat_data_o,
  a2p_req_if.src                                    req
);
  import avl_bridge_pkg::*;

  typedef enum logic {
    slv_idle,
    slv_burst
  } slv_state_t;

  slv_state_t state;
  burst_t     remain;     // Write beats still to come
  avl_addr_t  addr_q;
  burst_t     len_q;
  byte_en_t   fbe_q;
  logic       space_ok;
  logic       accept;
  logic       multi;
  logic       in_burst;

  // One command may still sit in the translator, hence 2
  assign space_ok = (cmd_free_i >= 2) && (wdat_free_i >= `MAX_BURST);
  assign in_burst = (state == slv_burst);

  assign avl_wait_request_o = !in_burst && !space_ok;
  assign accept = !in_burst && space_ok && (avl_read_i || avl_write_i);
  assign multi  = avl_write_i && (avl_burst_count_i > 1);

  // Every accepted write beat goes straight into the data FIFO
  assign wdat_push_o = avl_write_i && (accept || in_burst);
  assign wdat_data_o = avl_write_data_i;

  // A burst is announced on its last beat so its data is always
  // in the FIFO before the formatter sees the command
  assign req.valid = (accept && !multi) || (in_burst && avl_write_i && (remain == 1));
  assign req.write = in_burst || avl_write_i;
  assign req.addr  = in_burst ? addr_q : avl_address_i;
  assign req.len   = in_burst ? len_q  : avl_burst_count_i;
  assign req.fbe   = in_burst ? fbe_q  : avl_byte_enable_i;

  always_ff @(posedge Clk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      state  <= slv_idle;
      remain <= '0;
    end
    else
    begin
      case (state)
        slv_idle:
          if (accept && multi)
          begin
            state  <= slv_burst;
            remain <= avl_burst_count_i - burst_t'(1);
          end
        slv_burst:
          if (avl_write_i)
          begin
            remain <= remain - burst_t'(1);
            if (remain == 1)
              state <= slv_idle;  // Last beat
          end
        default: state <= slv_idle;
      endcase
    end
  end

  // First beat fields kept for the burst announcement
  always_ff @(posedge Clk_i)
  begin
    if (accept)
    begin
      addr_q <= avl_address_i;
      len_q  <= avl_burst_count_i;
      fbe_q  <= avl_byte_enable_i;
    end
  end

endmodule

// ==== src/tlp_formatter.sv ====
// ====================
// Builds MRd/MWr TLPs from command words and streams them out on a
// 32-bit valid/ready port. Holds the output beat while ready is low
// ====================
`include "tx_bridge_params.svh"

module tlp_formatter (
  input  logic                       Clk_i,
  input  logic                       Rstn_i,
  input  pcie_tlp_pkg::req_id_t      bus_dev_i,
  input  logic                       cmd_empty_i,
  output logic                       cmd_pop_o,
  input  pcie_tlp_pkg::tx_cmd_t      cmd_i,
  output logic                       wdat_pop_o,
  input  avl_bridge_pkg::data_word_t wdat_i,
  input  logic                       st_ready_i,
  output logic                       st_valid_o,
  output logic                       st_sop_o,
  output logic                       st_eop_o,
  output avl_bridge_pkg::data_word_t st_data_o,
  output logic                       tx_idle_o
);
  import avl_bridge_pkg::*;
  import pcie_tlp_pkg::*;

  typedef enum logic [2:0] {
    fsm_idle,
    fsm_fetch,
    fsm_header,
    fsm_address,
    fsm_data
  } fsm_state_t;

  fsm_state_t state;
  tx_cmd_t    cmd_q;
  burst_t     cnt;        // Beat index, or data words left
  tlp_tag_t   tag_cnt;
  logic       adv;
  logic       wr;
  logic       is64;
  burst_t     len;
  pcie_addr_t addr;
  tlp_fmt_t   fmt;
  data_word_t dw0;
  data_word_t dw1;

  // Output register free for a new beat
  assign adv = !st_valid_o || st_ready_i;

  assign wr   = cmd_q[`CMD_WR_BIT];
  assign len  = cmd_q[`CMD_LEN_HI:`CMD_LEN_LO];
  assign addr = cmd_q[`CMD_ADDR_HI:`CMD_ADDR_LO];
  assign is64 = |addr[63:32];  // 3-DW header when upper half is zero

  always_comb
  begin
    case ({wr, is64})
      2'b00:   fmt = MRd32;
      2'b01:   fmt = MRd64;
      2'b10:   fmt = MWr32;
      default: fmt = MWr64;
    endcase
  end

  assign dw0 = {fmt, 5'b00000, 14'h0, tlp_len_t'(len)};
  assign dw1 = {bus_dev_i, (wr ? tlp_tag_t'(0) : tag_cnt),
                ((len > 1) ? 4'hF : 4'h0), cmd_q[`CMD_FBE_HI:`CMD_FBE_LO]};

  assign cmd_pop_o = (state == fsm_idle) && !cmd_empty_i;
  // First word fetched early, the rest one ahead of each data beat
  assign wdat_pop_o = ((state == fsm_fetch) && cmd_i[`CMD_WR_BIT])
                    || ((state == fsm_data) && adv && (cnt > 1));
  assign tx_idle_o = (state == fsm_idle) && cmd_empty_i;

  always_ff @(posedge Clk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      state      <= fsm_idle;
      cnt        <= '0;
      tag_cnt    <= '0;
      st_valid_o <= 1'b0;
      st_sop_o   <= 1'b0;
      st_eop_o   <= 1'b0;
    end
    else
    begin
      if (st_valid_o && st_ready_i)
        st_valid_o <= 1'b0;  // Beat taken, cleared unless reloaded below
      case (state)
        fsm_idle:
          if (!cmd_empty_i)
            state <= fsm_fetch;
        fsm_fetch:
        begin
          cnt   <= '0;
          state <= fsm_header;
        end
        fsm_header:
          if (adv)
          begin
            st_valid_o <= 1'b1;
            st_sop_o   <= (cnt == 0);
            st_eop_o   <= 1'b0;
            if (cnt == 0)
              cnt <= burst_t'(1);
            else
            begin
              cnt   <= '0;
              state <= fsm_address;
              if (!wr)
                tag_cnt <= tag_cnt + 1'b1;  // Wraps
            end
          end
        fsm_address:
          if (adv)
          begin
            st_valid_o <= 1'b1;
            st_sop_o   <= 1'b0;
            if (is64 && (cnt == 0))
            begin
              st_eop_o <= 1'b0;
              cnt      <= burst_t'(1);
            end
            else
            begin
              st_eop_o <= !wr;  // Reads end on the address
              cnt      <= len;
              state    <= wr ? fsm_data : fsm_idle;
            end
          end
        fsm_data:
          if (adv)
          begin
            st_valid_o <= 1'b1;
            st_sop_o   <= 1'b0;
            st_eop_o   <= (cnt == 1);
            cnt        <= cnt - burst_t'(1);
            if (cnt == 1)
              state <= fsm_idle;
          end
        default: state <= fsm_idle;
      endcase
    end
  end

  always_ff @(posedge Clk_i)
  begin
    if (state == fsm_fetch)
      cmd_q <= cmd_i;
    if (adv)
    begin
      case (state)
        fsm_header:  st_data_o <= (cnt == 0) ? dw0 : dw1;
        fsm_address: st_data_o <= (is64 && (cnt == 0)) ? addr[63:32] : {addr[31:2], 2'b00};
        fsm_data:    st_data_o <= wdat_i;
        default:     ;
      endcase
    end
  end

endmodule

// ==== src/tx_bridge_top.sv ====
// ====================
// Avalon-MM to PCIe TLP transmit bridge. Avalon commands in, a
// 32-bit TLP stream out, table programmed over the config port
// ====================
`include "tx_bridge_params.svh"

module tx_bridge_top (
  input  logic                       Clk_i,
  input  logic                       Rstn_i,
  input  logic                       avl_read_i,
  input  logic                       avl_write_i,
  input  avl_bridge_pkg::avl_addr_t  avl_address_i,
  input  avl_bridge_pkg::burst_t     avl_burst_count_i,
  input  avl_bridge_pkg::byte_en_t   avl_byte_enable_i,
  input  avl_bridge_pkg::data_word_t avl_write_data_i,
  output logic                       avl_wait_request_o,
  input  avl_bridge_pkg::cfg_addr_t  cfg_address_i,
  input  logic                       cfg_write_i,
  input  logic                       cfg_read_i,
  input  avl_bridge_pkg::data_word_t cfg_write_data_i,
  output avl_bridge_pkg::data_word_t cfg_read_data_o,
  output logic                       cfg_read_valid_o,
  input  pcie_tlp_pkg::req_id_t      bus_dev_i,
  input  logic                       st_ready_i,
  output logic                       st_valid_o,
  output logic                       st_sop_o,
  output logic                       st_eop_o,
  output avl_bridge_pkg::data_word_t st_data_o,
  output logic                       tx_idle_o
);
  import avl_bridge_pkg::*;
  import pcie_tlp_pkg::*;

  a2p_req_if req_if ();

  a2p_table_t                                a2p_table;
  logic                                      cmd_push;
  tx_cmd_t                                   cmd_in;
  logic                                      cmd_pop;
  tx_cmd_t                                   cmd_out;
  logic                                      cmd_empty;
  logic [$clog2(`CMD_FIFO_DEPTH+1)-1:0]      cmd_free;
  logic                                      wdat_push;
  data_word_t                                wdat_in;
  logic                                      wdat_pop;
  data_word_t                                wdat_out;
  logic [$clog2(`WDAT_FIFO_DEPTH+1)-1:0]     wdat_free;

  avl_tx_slave u_slave (
    .Clk_i, .Rstn_i,
    .avl_read_i, .avl_write_i, .avl_address_i, .avl_burst_count_i,
    .avl_byte_enable_i, .avl_write_data_i, .avl_wait_request_o,
    .cmd_free_i (cmd_free),
    .wdat_free_i (wdat_free),
    .wdat_push_o (wdat_push),
    .wdat_data_o (wdat_in),
    .req (req_if.src)
  );

  a2p_table_regs u_table (
    .Clk_i, .Rstn_i,
    .cfg_address_i, .cfg_write_i, .cfg_write_data_i,
    .cfg_read_i, .cfg_read_data_o, .cfg_read_valid_o,
    .table_o (a2p_table)
  );

  a2p_translate u_translate (
    .Clk_i, .Rstn_i,
    .req (req_if.dst),
    .table_i (a2p_table),
    .cmd_push_o (cmd_push),
    .cmd_o (cmd_in)
  );

  sync_fifo #(.WIDTH(`CMD_W), .DEPTH(`CMD_FIFO_DEPTH)) cmd_fifo (
    .Clk_i, .Rstn_i,
    .push_i (cmd_push), .data_i (cmd_in),
    .pop_i (cmd_pop), .data_o (cmd_out),
    .empty_o (cmd_empty), .free_o (cmd_free)
  );

  // Empty flag unused, data is always pushed ahead of its command
  sync_fifo #(.WIDTH(`DATA_W), .DEPTH(`WDAT_FIFO_DEPTH)) wdat_fifo (
    .Clk_i, .Rstn_i,
    .push_i (wdat_push), .data_i (wdat_in),
    .pop_i (wdat_pop), .data_o (wdat_out),
    .empty_o (), .free_o (wdat_free)
  );

  tlp_formatter u_formatter (
    .Clk_i, .Rstn_i, .bus_dev_i,
    .cmd_empty_i (cmd_empty), .cmd_pop_o (cmd_pop), .cmd_i (cmd_out),
    .wdat_pop_o (wdat_pop), .wdat_i (wdat_out),
    .st_ready_i, .st_valid_o, .st_sop_o, .st_eop_o, .st_data_o,
    .tx_idle_o
  );

endmodule

// ==== verification/tx_bridge_tb.sv ====
// ====================
// Testbench for the Avalon to PCIe transmit bridge. Programs the
// table, sends writes and reads, and checks every TLP beat against
// a queue-based reference model, also under output stalls
// ====================
`include "tx_bridge_params.svh"

module tx_bridge_tb;
  import avl_bridge_pkg::*;
  import pcie_tlp_pkg::*;

  localparam int WAIT_LIMIT  = 200;   // Cycles for one Avalon accept
  localparam int DRAIN_LIMIT = 4000;

  logic       Clk_i;
  logic       Rstn_i;
  logic       avl_read_i;
  logic       avl_write_i;
  avl_addr_t  avl_address_i;
  burst_t     avl_burst_count_i;
  byte_en_t   avl_byte_enable_i;
  data_word_t avl_write_data_i;
  logic       avl_wait_request_o;
  cfg_addr_t  cfg_address_i;
  logic       cfg_write_i;
  logic       cfg_read_i;
  data_word_t cfg_write_data_i;
  data_word_t cfg_read_data_o;
  logic       cfg_read_valid_o;
  req_id_t    bus_dev_i;
  logic       st_ready_i;
  logic       st_valid_o;
  logic       st_sop_o;
  logic       st_eop_o;
  data_word_t st_data_o;
  logic       tx_idle_o;

  logic [31:0] lfsr = 32'h6329;
  data_word_t  tbl [2*`A2P_ENTRIES];   // Shadow of the table registers
  logic [33:0] exp_q [$];              // {sop, eop, data} per beat
  logic [33:0] exp_beat;
  tlp_tag_t    rd_tag;
  int          ready_mode;             // 0 ready, 1 random stalls, 2 held low
  int          value_errs;
  int          proto_errs;
  int          beat_cnt;
  bit          timed_out;

  tx_bridge_top UUT (.*);

  initial
  begin
    Clk_i = 1'b0;
    forever #50 Clk_i = ~Clk_i;
  end

  // Galois form, one step per bit taken
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] r;
    logic        lsb;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lsb  = lfsr[0];
      lfsr = lfsr >> 1;
      if (lsb)
        lfsr = lfsr ^ 32'h80200003;
      r = {r[30:0], lsb};
    end
    return r;
  endfunction

  always @(negedge Clk_i)
  begin
    case (ready_mode)
      1:       st_ready_i = (next_bits(2) != 0);  // About one stall in four
      2:       st_ready_i = 1'b0;
      default: st_ready_i = 1'b1;
    endcase
  end

  // Output beat checker
  always @(posedge Clk_i)
  begin
    if (Rstn_i && st_valid_o && st_ready_i)
    begin
      if (exp_q.size() == 0)
      begin
        proto_errs++;
        $display("Output beat %h arrived while no packet was expected", st_data_o);
      end
      else
      begin
        exp_beat = exp_q.pop_front();
        beat_cnt++;
        assert ({st_sop_o, st_eop_o, st_data_o} == exp_beat)
        else
        begin
          value_errs++;
          $display("Error at time %0t: beat sop %b eop %b data %h, expected sop %b eop %b data %h",
                   $time, st_sop_o, st_eop_o, st_data_o, exp_beat[33], exp_beat[32],
                   exp_beat[31:0]);
        end
      end
    end
  end

  cfg_valid_follows: assert property (@(posedge Clk_i) disable iff (!Rstn_i)
    cfg_read_i |=> cfg_read_valid_o)
  else
  begin
    proto_errs++;
    $display("Config read valid did not follow its read by one cycle at %0t", $time);
  end

  cfg_valid_quiet: assert property (@(posedge Clk_i) disable iff (!Rstn_i)
    !cfg_read_i |=> !cfg_read_valid_o)
  else
  begin
    proto_errs++;
    $display("Config read valid rose without a read at %0t", $time);
  end

  beat_holds: assert property (@(posedge Clk_i) disable iff (!Rstn_i)
    (st_valid_o && !st_ready_i) |=>
      (st_valid_o && $stable(st_data_o) && $stable(st_sop_o) && $stable(st_eop_o)))
  else
  begin
    proto_errs++;
    $display("Output beat changed during a stall at %0t", $time);
  end

  task automatic end_run();
    $display("Summary: %0d beats checked, %0d value errors, %0d protocol errors",
             beat_cnt, value_errs, proto_errs);
    if (!timed_out && value_errs == 0 && proto_errs == 0 && exp_q.size() == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  endtask

  // Later waits fall straight through once this is set
  task automatic flag_timeout(input string what);
    timed_out = 1'b1;
    $display("Timeout while waiting for %s", what);
  endtask

  // Expected beats of one TLP, straight from the header rules
  task automatic expect_tlp(input bit wr, input avl_addr_t addr, input int n,
                            input byte_en_t be, input logic [3:0][31:0] words);
    logic [63:0] base;
    logic [63:0] pa;
    logic        is64;
    tlp_fmt_t    fmt;
    tlp_tag_t    tag;
    tlp_len_t    len;
    int          idx;
    idx  = addr[`AVL_ADDR_W-1:`A2P_PASS_BITS];
    base = {tbl[2*idx+1], tbl[2*idx]};
    pa   = {base[63:`A2P_PASS_BITS], addr[`A2P_PASS_BITS-1:0]};
    is64 = (pa[63:32] != '0);
    fmt  = {1'b0, wr, is64};
    len  = n[9:0];
    tag  = wr ? '0 : rd_tag;
    if (!wr)
      rd_tag++;
    exp_q.push_back({1'b1, 1'b0, fmt, 5'b00000, 14'h0, len});
    exp_q.push_back({2'b00, bus_dev_i, tag, (n > 1) ? 4'hF : 4'h0, be});
    if (is64)
      exp_q.push_back({2'b00, pa[63:32]});
    exp_q.push_back({1'b0, !wr, pa[31:2], 2'b00});  // Reads end here
    for (int k = 0; wr && k < n; k++)
      exp_q.push_back({1'b0, k == n - 1, words[k]});
  endtask

  // Called and returns on a falling edge
  task automatic send_cmd(input bit wr, input int idx, input int n);
    logic [3:0][31:0] words;
    logic [31:0]      rnd;
    avl_addr_t        addr;
    byte_en_t         be;
    int               cnt;
    rnd  = next_bits(20);
    addr = {idx[1:0], rnd[19:0], 2'b00};   // Word aligned
    rnd  = next_bits(4);
    be   = rnd[3:0];
    for (int k = 0; k < 4; k++)
      words[k] = next_bits(32);
    avl_read_i        = !wr;
    avl_write_i       = wr;
    avl_address_i     = addr;
    avl_burst_count_i = n[2:0];
    avl_byte_enable_i = be;
    avl_write_data_i  = words[0];
    cnt = 0;
    while (avl_wait_request_o && !timed_out)
    begin
      if (cnt >= WAIT_LIMIT)
        flag_timeout("an Avalon command to be accepted");
      else
      begin
        @(negedge Clk_i);
        cnt++;
      end
    end
    if (!timed_out)
    begin
      expect_tlp(wr, addr, n, be, words);
      @(negedge Clk_i);
      for (int k = 1; wr && k < n; k++)
      begin
        avl_write_data_i = words[k];  // Burst beats need no wait
        @(negedge Clk_i);
      end
    end
    avl_read_i  = 1'b0;
    avl_write_i = 1'b0;
  endtask

  task automatic cfg_write(input int a, input data_word_t d);
    cfg_address_i    = a[2:0];
    cfg_write_data_i = d;
    cfg_write_i      = 1'b1;
    @(negedge Clk_i);
    cfg_write_i = 1'b0;
  endtask

  task automatic cfg_check(input int a);
    cfg_address_i = a[2:0];
    cfg_read_i    = 1'b1;
    @(negedge Clk_i);
    cfg_read_i = 1'b0;
    assert (cfg_read_valid_o && cfg_read_data_o == tbl[a])
    else
    begin
      value_errs++;
      $display("Error at time %0t: config word %0d read %h valid %b, expected %h",
               $time, a, cfg_read_data_o, cfg_read_valid_o, tbl[a]);
    end
  endtask

  task automatic drain(input string what);
    int cnt;
    cnt = 0;
    while ((exp_q.size() != 0 || !tx_idle_o) && !timed_out)
    begin
      if (cnt >= DRAIN_LIMIT)
        flag_timeout(what);
      else
      begin
        @(negedge Clk_i);
        cnt++;
      end
    end
  endtask

  initial
  begin
    int sent;
    bit saw_wait;
    Rstn_i = 1'b0;
    avl_read_i = 1'b0;
    avl_write_i = 1'b0;
    avl_address_i = '0;
    avl_burst_count_i = '0;
    avl_byte_enable_i = '0;
    avl_write_data_i = '0;
    cfg_address_i = '0;
    cfg_write_i = 1'b0;
    cfg_read_i = 1'b0;
    cfg_write_data_i = '0;
    bus_dev_i = 16'h0A18;
    st_ready_i = 1'b1;
    ready_mode = 0;
    rd_tag = '0;
    value_errs = 0;
    proto_errs = 0;
    beat_cnt = 0;
    timed_out = 1'b0;
    repeat (4) @(negedge Clk_i);
    Rstn_i = 1'b1;
    assert (!st_valid_o && !cfg_read_valid_o && !avl_wait_request_o && tx_idle_o)
    else
    begin
      value_errs++;
      $display("Error at time %0t: outputs after reset valid %b rvalid %b wait %b idle %b",
               $time, st_valid_o, cfg_read_valid_o, avl_wait_request_o, tx_idle_o);
    end
    for (int a = 0; a < 2*`A2P_ENTRIES; a++)
    begin
      tbl[a] = next_bits(32);
      cfg_write(a, tbl[a]);
    end
    for (int a = 0; a < 2*`A2P_ENTRIES; a++)
      cfg_check(a);
    // Entry 0 gives 3-DW headers, entry 1 always 4-DW
    tbl[1] = '0;
    cfg_write(1, tbl[1]);
    tbl[3] = tbl[3] | 32'h1;
    cfg_write(3, tbl[3]);
    cfg_check(1);
    cfg_check(3);
    send_cmd(1'b1, 0, 1);
    drain("the short write packet");
    send_cmd(1'b1, 1, `MAX_BURST);
    drain("the long write packet");
    repeat (5) send_cmd(1'b0, next_bits(2), 1 + next_bits(2));
    drain("the read packets");
    ready_mode = 1;
    repeat (12) send_cmd(next_bits(1) != 0, next_bits(2), 1 + next_bits(2));
    drain("the traffic under random stalls");
    // Long stall until the FIFOs fill up
    ready_mode = 2;
    sent = 0;
    saw_wait = 1'b0;
    while (!saw_wait && sent < 24 && !timed_out)
    begin
      if (avl_wait_request_o)
        saw_wait = 1'b1;
      else
      begin
        send_cmd(1'b1, next_bits(2), `MAX_BURST);
        sent++;
      end
    end
    if (!timed_out)
    begin
      assert (saw_wait)
      else
      begin
        proto_errs++;
        $display("Wait-request never rose during the long output stall");
      end
    end
    ready_mode = 0;
    drain("the traffic after the stall");
    end_run();
  end

endmodule

// ==== sources.f ====
+incdir+common
common/avl_bridge_pkg.sv
common/pcie_tlp_pkg.sv
common/a2p_req_if.sv
src/sync_fifo.sv
a2p/a2p_table_regs.sv
a2p/a2p_translate.sv
src/avl_tx_slave.sv
src/tlp_formatter.sv
src/tx_bridge_top.sv
verification/tx_bridge_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compiles the bridge and its testbench with Verilator, runs the
# simulation and fails unless the pass message shows up
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tx_bridge_tb -f sources.f

out=$(./obj_dir/Vtx_bridge_tb)
echo "$out"

if echo "$out" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1
